//--- flist.f
design/tcp_proto_pkg.sv
design/ip_stream_pkg.sv
design/tcp_opt_assembler.sv
design/tcp_cks_engine.sv
design/tcp_hdr_serializer.sv
design/tcp_tx_top.sv
sim/tcp_tx_asserts.sv
sim/tcp_tx_tb.sv

//--- Bender.yml
package:
  name: tcp_tx

sources:
  - design/tcp_proto_pkg.sv
  - design/ip_stream_pkg.sv
  - design/tcp_opt_assembler.sv
  - design/tcp_cks_engine.sv
  - design/tcp_hdr_serializer.sv
  - design/tcp_tx_top.sv
  - target: simulation
    files:
      - sim/tcp_tx_asserts.sv
      - sim/tcp_tx_tb.sv

//--- sim/tcp_tx_tb.sv
`timescale 1ns/1ps

module tcp_tx_tb;

  localparam int num_segs       = 40;
  localparam int timeout_cycles = num_segs * 400;

  logic        clk = 1'b0;
  logic        rst;
  logic        meta_rdy, meta_ack;
  logic [31:0] src_ip, dst_ip, seq_num, ack_num, pld_cks, ts_val, ts_ecr;
  logic [15:0] src_port, dst_port, win_size, urg_ptr, pld_len, mss;
  logic [8:0]  flags;
  logic        mss_pres, ws_pres, sack_perm_pres, sack_pres, ts_pres;
  logic [7:0]  ws_shift;
  logic [2:0]  sack_blocks;
  logic [31:0] sack_left [4];
  logic [31:0] sack_right [4];
  logic        pld_req, ip_rdy, ip_ack, ip_req, ip_val, ip_sof, ip_eof;
  logic [7:0]  pld_dat, ip_dat;
  logic [15:0] ip_len;
  logic [31:0] ip_src, ip_dst;

  // Reference model state
  logic [9:0]  exp_q[$];   // {sof, eof, byte}
  logic [79:0] meta_q[$];  // {src, dst, tcp length}
  logic        exp_have = 1'b0, exp_sof, exp_eof;
  logic [7:0]  exp_dat;
  logic [31:0] exp_src, exp_dst;
  logic [15:0] exp_len;
  int          frames_seen = 0;
  int          pld_base = 0;
  int          pld_pos = 0;
  int          cycle_cnt = 0;

  tcp_tx_top tcp_tx_top_i (.*);

  bind tcp_tx_top tcp_tx_asserts tcp_tx_asserts_i (.*);

  always #4 clk = ~clk;

  function automatic logic [7:0] pay_byte(input int k);
    return 8'(k * 7) ^ 8'(k >> 5);  // Known payload stream, all frames in order
  endfunction

  function automatic logic [31:0] payload_sum(input int base, input int len);
    logic [31:0] sum;
    sum = 0;
    for (int k = 0; k < len; k += 2) begin
      if (k + 1 < len) sum += {pay_byte(base + k), pay_byte(base + k + 1)};
      else sum += {pay_byte(base + k), 8'h00};  // Odd tail padded with zero
    end
    return sum;
  endfunction

  task automatic put_bytes(ref logic [7:0] q[$], input logic [31:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) q.push_back(v[8*i +: 8]);
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("Fail at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Run aborted");
  endtask

  // Expected frame from the segment now on the inputs
  task automatic queue_expected_frame(input int base);
    logic [31:0] words[$];
    logic [7:0]  hdr[$];
    logic [31:0] sum;
    logic [15:0] cks, tcp_len;
    int          used, blocks;
    used   = int'(mss_pres) + int'(ws_pres) + int'(sack_perm_pres) + (ts_pres ? 3 : 0);
    blocks = sack_pres ? int'(sack_blocks) : 0;
    while (blocks > 0 && used + 1 + 2 * blocks > 10) blocks--;  // Drop from the top
    if (mss_pres) words.push_back({8'd2, 8'd4, mss});
    if (ws_pres) words.push_back({8'd1, 8'd3, 8'd3, ws_shift});
    if (sack_perm_pres) words.push_back({8'd1, 8'd1, 8'd4, 8'd2});
    if (blocks > 0) begin
      words.push_back({8'd1, 8'd1, 8'd5, 8'(8 * blocks + 2)});
      for (int b = 0; b < blocks; b++) begin
        words.push_back(sack_left[b]);
        words.push_back(sack_right[b]);
      end
    end
    if (ts_pres) begin
      words.push_back({8'd1, 8'd1, 8'd8, 8'd10});
      words.push_back(ts_val);
      words.push_back(ts_ecr);
    end
    put_bytes(hdr, {src_port, dst_port}, 4);
    put_bytes(hdr, seq_num, 4);
    put_bytes(hdr, ack_num, 4);
    put_bytes(hdr, {4'(5 + words.size()), 3'b000, flags, win_size}, 4);
    put_bytes(hdr, {16'h0000, urg_ptr}, 4);
    foreach (words[i]) put_bytes(hdr, words[i], 4);
    tcp_len = 16'(hdr.size()) + pld_len;
    sum = src_ip[31:16] + src_ip[15:0] + dst_ip[31:16] + dst_ip[15:0] + 32'h6 + tcp_len;
    sum += pld_cks;
    for (int i = 0; i < hdr.size(); i += 2) sum += {hdr[i], hdr[i+1]};
    while (sum > 32'hffff) sum = (sum & 32'hffff) + (sum >> 16);
    cks     = ~sum[15:0];
    hdr[16] = cks[15:8];
    hdr[17] = cks[7:0];
    foreach (hdr[i]) exp_q.push_back({i == 0, i == hdr.size() - 1 && pld_len == 0, hdr[i]});
    for (int k = 0; k < pld_len; k++)
      exp_q.push_back({1'b0, k == pld_len - 1, pay_byte(base + k)});
    meta_q.push_back({src_ip, dst_ip, tcp_len});
  endtask

  task automatic send_segment(input int idx);
    int   len;
    logic no_opts, all_opts;
    no_opts  = (idx % 8 == 0);
    all_opts = (idx % 8 == 1);  // Forces SACK trimming
    len      = (idx % 8 == 2) ? 0 : $urandom_range(64, 0);
    @(posedge clk);
    meta_rdy       <= 1'b1;
    src_ip         <= $urandom();
    dst_ip         <= $urandom();
    src_port       <= 16'($urandom());
    dst_port       <= 16'($urandom());
    seq_num        <= $urandom();
    ack_num        <= $urandom();
    flags          <= 9'($urandom());
    win_size       <= 16'($urandom());
    urg_ptr        <= 16'($urandom());
    mss            <= 16'($urandom());
    ws_shift       <= 8'($urandom_range(14, 0));
    ts_val         <= $urandom();
    ts_ecr         <= $urandom();
    mss_pres       <= !no_opts && (all_opts || $urandom_range(1, 0));
    ws_pres        <= !no_opts && (all_opts || $urandom_range(1, 0));
    sack_perm_pres <= !no_opts && (all_opts || $urandom_range(1, 0));
    sack_pres      <= !no_opts && (all_opts || $urandom_range(1, 0));
    ts_pres        <= !no_opts && (all_opts || $urandom_range(1, 0));
    sack_blocks    <= all_opts ? 3'd4 : 3'($urandom_range(4, 0));
    for (int i = 0; i < 4; i++) begin
      sack_left[i]  <= $urandom();
      sack_right[i] <= $urandom();
    end
    pld_len  <= 16'(len);
    pld_cks  <= payload_sum(pld_base, len);
    pld_base += len;
    @(posedge clk);
    queue_expected_frame(pld_base - len);
    while (!meta_ack) @(posedge clk);
    meta_rdy <= 1'b0;
  endtask

  // IPv4 sink with a random acknowledge delay
  initial begin
    forever begin
      @(posedge clk);
      if (ip_rdy && !rst) begin
        repeat ($urandom_range(10, 0)) @(posedge clk);
        ip_ack <= 1'b1;
        @(posedge clk);
        ip_ack <= 1'b0;
        ip_req <= 1'b1;
        do @(posedge clk); while (!(ip_val && ip_eof));
        ip_req <= 1'b0;
      end
    end
  end

  // Payload source, one byte after each request cycle
  always @(posedge clk) begin
    if (pld_req) begin
      pld_dat <= pay_byte(pld_pos);
      pld_pos <= pld_pos + 1;
    end
  end

  // Advance the expected stream as bytes leave the DUT
  always @(posedge clk) begin
    if (ip_val && exp_q.size() != 0) void'(exp_q.pop_front());
    if (ip_val && ip_eof) begin
      if (meta_q.size() != 0) void'(meta_q.pop_front());
      frames_seen <= frames_seen + 1;
    end
    exp_have <= (exp_q.size() != 0);
    if (exp_q.size() != 0) {exp_sof, exp_eof, exp_dat} <= exp_q[0];
    if (meta_q.size() != 0) {exp_src, exp_dst, exp_len} <= meta_q[0];
  end

  no_extra_byte: assert property (@(posedge clk) disable iff (rst) ip_val |-> exp_have)
    else abort_run("The DUT sent a byte that no segment accounts for");
  dat_ok: assert property (@(posedge clk) disable iff (rst) ip_val |-> ip_dat == exp_dat)
    else value_mismatch("ip_dat", $sampled(ip_dat), $sampled(exp_dat));
  sof_ok: assert property (@(posedge clk) disable iff (rst) ip_val |-> ip_sof == exp_sof)
    else value_mismatch("ip_sof", $sampled(ip_sof), $sampled(exp_sof));
  eof_ok: assert property (@(posedge clk) disable iff (rst) ip_val |-> ip_eof == exp_eof)
    else value_mismatch("ip_eof", $sampled(ip_eof), $sampled(exp_eof));
  len_ok: assert property (@(posedge clk) disable iff (rst) ip_rdy |-> ip_len == exp_len)
    else value_mismatch("ip_len", $sampled(ip_len), $sampled(exp_len));
  src_ok: assert property (@(posedge clk) disable iff (rst) ip_rdy |-> ip_src == exp_src)
    else value_mismatch("ip_src", $sampled(ip_src), $sampled(exp_src));
  dst_ok: assert property (@(posedge clk) disable iff (rst) ip_rdy |-> ip_dst == exp_dst)
    else value_mismatch("ip_dst", $sampled(ip_dst), $sampled(exp_dst));

  // Run limit and protocol watch
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles)
      abort_run("The run timed out before all frames arrived");
    else if (tcp_tx_top_i.tcp_tx_asserts_i.err_cnt != 0)
      abort_run("A protocol assertion on the top level ports failed");
  end

  initial begin
    void'($urandom(79));
    rst            = 1'b1;
    meta_rdy       = 1'b0;
    {src_ip, dst_ip, seq_num, ack_num, pld_cks, ts_val, ts_ecr} = '0;
    {src_port, dst_port, win_size, urg_ptr, pld_len, mss} = '0;
    flags          = '0;
    {mss_pres, ws_pres, sack_perm_pres, sack_pres, ts_pres} = '0;
    ws_shift       = '0;
    sack_blocks    = '0;
    sack_left      = '{default: '0};
    sack_right     = '{default: '0};
    ip_ack         = 1'b0;
    ip_req         = 1'b0;
    pld_dat        = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < num_segs; i++) send_segment(i);
    while (frames_seen < num_segs) @(posedge clk);
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0 || tcp_tx_top_i.tcp_tx_asserts_i.err_cnt != 0) begin
      $display("Frames ended with expected bytes left over");
      $display("Some tests failed");
      $fatal(1, "Run ended with errors");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule : tcp_tx_tb

//--- sim/tcp_tx_asserts.sv
`timescale 1ns/1ps

module tcp_tx_asserts (
  input logic clk,
  input logic rst,
  input logic meta_rdy,
  input logic meta_ack,
  input logic ip_rdy,
  input logic ip_ack,
  input logic ip_req,
  input logic ip_val,
  input logic ip_sof,
  input logic ip_eof,
  input logic pld_req
);

  int err_cnt = 0;  // Polled by the testbench

  // Segment handshake
  ack_needs_rdy: assert property (@(posedge clk) disable iff (rst) meta_ack |-> meta_rdy)
    else begin
      $error("meta_ack pulsed while meta_rdy was low");
      err_cnt++;
    end

  // Frame framing on the IPv4 side
  frame_starts_with_sof: assert property (@(posedge clk) disable iff (rst)
    $rose(ip_val) |-> ip_sof)
    else begin
      $error("ip_val rose without ip_sof");
      err_cnt++;
    end

  frame_contiguous: assert property (@(posedge clk) disable iff (rst)
    ip_val && !ip_eof |=> ip_val && !ip_sof)
    else begin
      $error("Gap or second sof inside a frame");
      err_cnt++;
    end

  frame_ends_after_eof: assert property (@(posedge clk) disable iff (rst)
    ip_val && ip_eof |=> !ip_val)
    else begin
      $error("ip_val still high after ip_eof");
      err_cnt++;
    end

  pld_req_in_frame: assert property (@(posedge clk) disable iff (rst) pld_req |-> ip_req)
    else begin
      $error("pld_req high while ip_req was low");
      err_cnt++;
    end

endmodule : tcp_tx_asserts

//--- design/tcp_tx_top.sv
`timescale 1ns/1ps

module tcp_tx_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     meta_rdy,
  output logic                     meta_ack,
  input  ip_stream_pkg::ip_addr_t  src_ip, dst_ip,
  input  tcp_proto_pkg::port_t     src_port, dst_port,
  input  tcp_proto_pkg::seq_t      seq_num, ack_num,
  input  tcp_proto_pkg::flags_t    flags,
  input  tcp_proto_pkg::win_t      win_size, urg_ptr,
  input  ip_stream_pkg::length_t   pld_len,
  input  ip_stream_pkg::cks_acc_t  pld_cks,
  input  logic                     mss_pres,
  input  tcp_proto_pkg::win_t      mss,
  input  logic                     ws_pres,
  input  logic [7:0]               ws_shift,
  input  logic                     sack_perm_pres,
  input  logic                     sack_pres,
  input  tcp_proto_pkg::sack_cnt_t sack_blocks,
  input  tcp_proto_pkg::seq_t      sack_left  [tcp_proto_pkg::max_sack_blocks],
  input  tcp_proto_pkg::seq_t      sack_right [tcp_proto_pkg::max_sack_blocks],
  input  logic                     ts_pres,
  input  tcp_proto_pkg::seq_t      ts_val, ts_ecr,
  output logic                     pld_req,
  input  ip_stream_pkg::byte_t     pld_dat,
  output logic                     ip_rdy,
  input  logic                     ip_ack,
  input  logic                     ip_req,
  output ip_stream_pkg::length_t   ip_len,
  output ip_stream_pkg::ip_addr_t  ip_src, ip_dst,
  output logic                     ip_val,
  output logic                     ip_sof,
  output logic                     ip_eof,
  output ip_stream_pkg::byte_t     ip_dat
);
  import tcp_proto_pkg::*;
  import ip_stream_pkg::*;

  // Stage 1 to stage 2
  logic       s1_val;
  opt_block_t s1_opt_block;
  offset_t    s1_offset;
  ip_addr_t   s1_src_ip, s1_dst_ip;
  port_t      s1_src_port, s1_dst_port;
  seq_t       s1_seq_num, s1_ack_num;
  flags_t     s1_flags;
  win_t       s1_win_size, s1_urg_ptr;
  length_t    s1_pld_len;
  cks_acc_t   s1_pld_cks;
  logic       s2_busy;

  // Stage 2 to stage 3
  logic       s2_val;
  hdr_bytes_t s2_hdr;
  length_t    s2_hdr_len, s2_pld_len;
  ip_addr_t   s2_src_ip, s2_dst_ip;
  logic       s3_busy;

  // Port names line up stage to stage
  tcp_opt_assembler tcp_opt_assembler_i (.*);

  tcp_cks_engine tcp_cks_engine_i (.*);

  tcp_hdr_serializer tcp_hdr_serializer_i (.*);

endmodule : tcp_tx_top

//--- design/tcp_hdr_serializer.sv
`timescale 1ns/1ps

module tcp_hdr_serializer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      s2_val,
  input  tcp_proto_pkg::hdr_bytes_t s2_hdr,
  input  ip_stream_pkg::length_t    s2_hdr_len,
  input  ip_stream_pkg::length_t    s2_pld_len,
  input  ip_stream_pkg::ip_addr_t   s2_src_ip, s2_dst_ip,
  output logic                      s3_busy,
  output logic                      ip_rdy,
  input  logic                      ip_ack,
  input  logic                      ip_req,
  output ip_stream_pkg::length_t    ip_len,
  output ip_stream_pkg::ip_addr_t   ip_src, ip_dst,
  output logic                      ip_val,
  output logic                      ip_sof,
  output logic                      ip_eof,
  output ip_stream_pkg::byte_t      ip_dat,
  output logic                      pld_req,
  input  ip_stream_pkg::byte_t      pld_dat
);
  import tcp_proto_pkg::*;
  import ip_stream_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_rdy,
    st_hdr,
    st_pld,
    st_done
  } state_t;

  state_t     state;
  hdr_bytes_t hdr_sr;   // Byte 0 is the next one out
  length_t    hdr_len, pld_len;
  length_t    hdr_cnt, pld_cnt, req_cnt;
  logic       hdr_go;

  // Stream starts on the first ip_req and then runs without a pause
  assign hdr_go  = (state == st_hdr) && (ip_req || hdr_cnt != '0);
  assign s3_busy = (state != st_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      ip_rdy  <= 1'b0;
      ip_val  <= 1'b0;
      ip_sof  <= 1'b0;
      ip_eof  <= 1'b0;
      pld_req <= 1'b0;
      hdr_cnt <= '0;
      pld_cnt <= '0;
      req_cnt <= '0;
    end else begin
      if (pld_req) begin  // Exactly pld_len request cycles
        req_cnt <= req_cnt + 16'd1;
        if (req_cnt == pld_len - 16'd1) pld_req <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (s2_val) begin
            ip_rdy  <= 1'b1;
            hdr_cnt <= '0;
            pld_cnt <= '0;
            req_cnt <= '0;
            state   <= st_rdy;
          end
        end
        st_rdy: begin
          if (ip_ack) begin
            ip_rdy <= 1'b0;
            state  <= st_hdr;
          end
        end
        st_hdr: begin
          if (hdr_go) begin
            ip_val  <= 1'b1;
            ip_sof  <= (hdr_cnt == '0);
            hdr_cnt <= hdr_cnt + 16'd1;
            if (hdr_cnt == hdr_len - 16'd2 && pld_len != '0)
              pld_req <= 1'b1;  // First payload byte is ready right after the header
            if (hdr_cnt == hdr_len - 16'd1) begin
              ip_eof <= (pld_len == '0);
              state  <= (pld_len == '0) ? st_done : st_pld;
            end
          end
        end
        st_pld: begin
          ip_sof  <= 1'b0;
          pld_cnt <= pld_cnt + 16'd1;
          if (pld_cnt == pld_len - 16'd1) begin
            ip_eof <= 1'b1;
            state  <= st_done;
          end
        end
        st_done: begin  // Last byte is on the bus this cycle
          ip_val <= 1'b0;
          ip_sof <= 1'b0;
          ip_eof <= 1'b0;
          state  <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && s2_val) begin
      hdr_sr  <= s2_hdr;
      hdr_len <= s2_hdr_len;
      pld_len <= s2_pld_len;
      ip_len  <= s2_hdr_len + s2_pld_len;  // TCP length for the IPv4 header
      ip_src  <= s2_src_ip;
      ip_dst  <= s2_dst_ip;
    end
    if (hdr_go) begin
      ip_dat <= hdr_sr[0];
      hdr_sr <= hdr_sr << $bits(byte_t);
    end else if (state == st_pld) begin
      ip_dat <= pld_dat;
    end
  end

endmodule : tcp_hdr_serializer

//--- design/tcp_cks_engine.sv
`timescale 1ns/1ps

module tcp_cks_engine (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      s1_val,
  input  tcp_proto_pkg::opt_block_t s1_opt_block,
  input  tcp_proto_pkg::offset_t    s1_offset,
  input  ip_stream_pkg::ip_addr_t   s1_src_ip, s1_dst_ip,
  input  tcp_proto_pkg::port_t      s1_src_port, s1_dst_port,
  input  tcp_proto_pkg::seq_t       s1_seq_num, s1_ack_num,
  input  tcp_proto_pkg::flags_t     s1_flags,
  input  tcp_proto_pkg::win_t       s1_win_size, s1_urg_ptr,
  input  ip_stream_pkg::length_t    s1_pld_len,
  input  ip_stream_pkg::cks_acc_t   s1_pld_cks,
  input  logic                      s3_busy,
  output logic                      s2_busy,
  output logic                      s2_val,
  output tcp_proto_pkg::hdr_bytes_t s2_hdr,
  output ip_stream_pkg::length_t    s2_hdr_len,
  output ip_stream_pkg::length_t    s2_pld_len,
  output ip_stream_pkg::ip_addr_t   s2_src_ip, s2_dst_ip
);
  import tcp_proto_pkg::*;
  import ip_stream_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_pseudo,
    st_hdr,
    st_fold,
    st_send
  } state_t;

  state_t                          state;
  logic [4:0]                      cnt;
  cks_word_t [0:pseudo_hdr_words-1] ps_hdr;
  cks_acc_t                        ps_acc, hdr_acc;
  cks_acc_t                        sum_all;
  logic [16:0]                     fold1;
  cks_word_t                       fold2, cks, hdr_word;
  logic [0:min_hdr_bytes-1][7:0]   fix_hdr;
  length_t                         hdr_len_in;

  assign hdr_len_in = length_t'({s1_offset, 2'b00});

  // Fixed part with a zero checksum field
  assign fix_hdr = {s1_src_port, s1_dst_port, s1_seq_num, s1_ack_num,
                    s1_offset, 3'b000, s1_flags, s1_win_size, 16'h0000, s1_urg_ptr};

  assign hdr_word = {s2_hdr[{cnt, 1'b0}], s2_hdr[{cnt, 1'b1}]};

  // End-around carry fold
  assign sum_all = ps_acc + hdr_acc;
  assign fold1   = 17'(sum_all[31:16]) + 17'(sum_all[15:0]);
  assign fold2   = fold1[15:0] + 16'(fold1[16]);
  assign cks     = ~fold2;

  assign s2_busy = (state != st_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      s2_val <= 1'b0;
      cnt    <= '0;
    end else begin
      s2_val <= 1'b0;
      case (state)
        st_idle: begin
          if (s1_val) begin
            cnt   <= '0;
            state <= st_pseudo;
          end
        end
        st_pseudo: begin
          if (cnt == 5'(pseudo_hdr_words - 1)) begin
            cnt   <= '0;
            state <= st_hdr;
          end else begin
            cnt <= cnt + 5'd1;
          end
        end
        st_hdr: begin
          cnt <= cnt + 5'd1;
          if (cnt + 5'd1 == s2_hdr_len[5:1]) state <= st_fold;  // Length set by the offset
        end
        st_fold: state <= st_send;
        st_send: begin
          if (!s3_busy) begin
            s2_val <= 1'b1;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (s1_val) begin
          s2_hdr     <= {fix_hdr, s1_opt_block};
          s2_hdr_len <= hdr_len_in;
          s2_pld_len <= s1_pld_len;
          s2_src_ip  <= s1_src_ip;
          s2_dst_ip  <= s1_dst_ip;
          ps_hdr     <= {s1_src_ip, s1_dst_ip, 8'h00, proto_tcp, hdr_len_in + s1_pld_len};
          ps_acc     <= '0;
          hdr_acc    <= s1_pld_cks;  // Payload sum seeds the header side
        end
      end
      st_pseudo: ps_acc <= ps_acc + cks_acc_t'(ps_hdr[cnt]);
      st_hdr:    hdr_acc <= hdr_acc + cks_acc_t'(hdr_word);
      st_fold: begin
        s2_hdr[tcp_cks_byte]     <= cks[15:8];
        s2_hdr[tcp_cks_byte + 1] <= cks[7:0];
      end
      default: ;
    endcase
  end

endmodule : tcp_cks_engine

//--- design/tcp_opt_assembler.sv
`timescale 1ns/1ps

module tcp_opt_assembler (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      meta_rdy,
  output logic                      meta_ack,
  input  ip_stream_pkg::ip_addr_t   src_ip, dst_ip,
  input  tcp_proto_pkg::port_t      src_port, dst_port,
  input  tcp_proto_pkg::seq_t       seq_num, ack_num,
  input  tcp_proto_pkg::flags_t     flags,
  input  tcp_proto_pkg::win_t       win_size, urg_ptr,
  input  ip_stream_pkg::length_t    pld_len,
  input  ip_stream_pkg::cks_acc_t   pld_cks,
  input  logic                      mss_pres,
  input  tcp_proto_pkg::win_t       mss,
  input  logic                      ws_pres,
  input  logic [7:0]                ws_shift,
  input  logic                      sack_perm_pres,
  input  logic                      sack_pres,
  input  tcp_proto_pkg::sack_cnt_t  sack_blocks,
  input  tcp_proto_pkg::seq_t       sack_left  [tcp_proto_pkg::max_sack_blocks],
  input  tcp_proto_pkg::seq_t       sack_right [tcp_proto_pkg::max_sack_blocks],
  input  logic                      ts_pres,
  input  tcp_proto_pkg::seq_t       ts_val, ts_ecr,
  input  logic                      s2_busy,
  output logic                      s1_val,
  output tcp_proto_pkg::opt_block_t s1_opt_block,
  output tcp_proto_pkg::offset_t    s1_offset,
  output ip_stream_pkg::ip_addr_t   s1_src_ip, s1_dst_ip,
  output tcp_proto_pkg::port_t      s1_src_port, s1_dst_port,
  output tcp_proto_pkg::seq_t       s1_seq_num, s1_ack_num,
  output tcp_proto_pkg::flags_t     s1_flags,
  output tcp_proto_pkg::win_t       s1_win_size, s1_urg_ptr,
  output ip_stream_pkg::length_t    s1_pld_len,
  output ip_stream_pkg::cks_acc_t   s1_pld_cks
);
  import tcp_proto_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_send
  } state_t;

  state_t                     state;
  opt_word_t [opt_proto_words-1:0] proto;  // Index 0 leaves first
  logic [opt_proto_words-1:0] pres;
  logic [opt_proto_words-1:0] pres_in;
  logic [3:0]                 sh_cnt;
  logic [3:0]                 base_words;
  logic [3:0]                 room;
  sack_cnt_t                  blk_req, blk_cap, blk_fit;
  logic [max_sack_blocks-1:0] blk_on;
  logic [7:0]                 sack_len;

  // SACK trimming against the word limit
  always_comb begin
    base_words = 4'(mss_pres) + 4'(ws_pres) + 4'(sack_perm_pres) + (ts_pres ? 4'd3 : 4'd0);
    room       = 4'(max_opt_words) - base_words;
    blk_cap    = sack_cnt_t'((room - 4'd1) >> 1);  // SACK kind word takes one
    blk_req    = (sack_blocks > sack_cnt_t'(max_sack_blocks)) ?
                 sack_cnt_t'(max_sack_blocks) : sack_blocks;
    if (!sack_pres)
      blk_fit = '0;
    else if (blk_req > blk_cap)
      blk_fit = blk_cap;  // Highest blocks go first
    else
      blk_fit = blk_req;
    for (int i = 0; i < max_sack_blocks; i++) begin
      blk_on[i] = (sack_cnt_t'(i) < blk_fit);
    end
  end

  assign sack_len = {2'b00, blk_fit, 3'b000} + tcp_opt_len_sack_base;

  // Same order as the prototype words below
  assign pres_in = {mss_pres, ws_pres, sack_perm_pres, blk_fit != '0,
                    {2{blk_on[0]}}, {2{blk_on[1]}}, {2{blk_on[2]}}, {2{blk_on[3]}},
                    {3{ts_pres}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      meta_ack <= 1'b0;
      s1_val   <= 1'b0;
      sh_cnt   <= '0;
    end else begin
      meta_ack <= 1'b0;
      s1_val   <= 1'b0;
      case (state)
        st_idle: begin
          if (meta_rdy) begin
            meta_ack <= 1'b1;
            sh_cnt   <= (|pres_in) ? 4'd0 : 4'(opt_proto_words - 1);  // Skip the walk
            state    <= st_shift;
          end
        end
        st_shift: begin
          sh_cnt <= sh_cnt + 4'd1;
          if (sh_cnt == 4'(opt_proto_words - 1)) state <= st_send;
        end
        st_send: begin
          if (!s2_busy) begin  // Hold the segment while stage 2 works
            s1_val <= 1'b1;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && meta_rdy) begin
      s1_src_ip    <= src_ip;
      s1_dst_ip    <= dst_ip;
      s1_src_port  <= src_port;
      s1_dst_port  <= dst_port;
      s1_seq_num   <= seq_num;
      s1_ack_num   <= ack_num;
      s1_flags     <= flags;
      s1_win_size  <= win_size;
      s1_urg_ptr   <= urg_ptr;
      s1_pld_len   <= pld_len;
      s1_pld_cks   <= pld_cks;
      s1_opt_block <= '0;  // Unused tail stays zero
      s1_offset    <= offset_t'(min_offset);
      pres         <= pres_in;
      proto        <= {{tcp_opt_kind_mss, tcp_opt_len_mss, mss},
                       {tcp_opt_kind_nop, tcp_opt_kind_ws, tcp_opt_len_ws, ws_shift},
                       {tcp_opt_kind_nop, tcp_opt_kind_nop,
                        tcp_opt_kind_sack_perm, tcp_opt_len_sack_perm},
                       {tcp_opt_kind_nop, tcp_opt_kind_nop, tcp_opt_kind_sack, sack_len},
                       sack_left[0], sack_right[0], sack_left[1], sack_right[1],
                       sack_left[2], sack_right[2], sack_left[3], sack_right[3],
                       {tcp_opt_kind_nop, tcp_opt_kind_nop, tcp_opt_kind_ts, tcp_opt_len_ts},
                       ts_val, ts_ecr};
    end else if (state == st_shift) begin
      proto <= proto >> $bits(opt_word_t);
      pres  <= pres >> 1;
      if (pres[0]) begin  // Last word pushed in ends up at byte 0
        s1_opt_block <= {proto[0], s1_opt_block[0:opt_block_bytes-5]};
        s1_offset    <= s1_offset + 4'd1;
      end
    end
  end

endmodule : tcp_opt_assembler

//--- design/ip_stream_pkg.sv
package ip_stream_pkg;

  // Byte stream toward the IPv4 layer
  localparam int stream_w = 8;

  typedef logic [stream_w-1:0] byte_t;

  // Lengths and addresses
  typedef logic [15:0] length_t;
  typedef logic [31:0] ip_addr_t;

  // Checksum arithmetic
  typedef logic [31:0] cks_acc_t;   // Carries stay above bit 15 until the fold
  typedef logic [15:0] cks_word_t;

  // Pseudo header
  localparam byte_t proto_tcp        = 8'd6;
  localparam int    pseudo_hdr_words = 6;  // Two addresses, zero and protocol, TCP length

endpackage : ip_stream_pkg

//--- design/tcp_proto_pkg.sv
package tcp_proto_pkg;

  // Option kind codes, one byte each
  localparam logic [7:0] tcp_opt_kind_nop       = 8'd1;
  localparam logic [7:0] tcp_opt_kind_mss       = 8'd2;
  localparam logic [7:0] tcp_opt_kind_ws        = 8'd3;
  localparam logic [7:0] tcp_opt_kind_sack_perm = 8'd4;
  localparam logic [7:0] tcp_opt_kind_sack      = 8'd5;
  localparam logic [7:0] tcp_opt_kind_ts        = 8'd8;

  // Option length bytes as carried on the wire
  localparam logic [7:0] tcp_opt_len_mss       = 8'd4;
  localparam logic [7:0] tcp_opt_len_ws        = 8'd3;
  localparam logic [7:0] tcp_opt_len_sack_perm = 8'd2;
  localparam logic [7:0] tcp_opt_len_sack_base = 8'd2;  // Plus 8 per SACK block
  localparam logic [7:0] tcp_opt_len_ts        = 8'd10;

  // Header size limits
  localparam int min_hdr_bytes   = 20;
  localparam int max_hdr_bytes   = 60;
  localparam int opt_block_bytes = max_hdr_bytes - min_hdr_bytes;
  localparam int min_offset      = 5;   // Data offset without options
  localparam int tcp_cks_byte    = 16;  // First byte of the checksum field

  // Option block limits
  localparam int max_opt_words   = 10;
  localparam int max_sack_blocks = 4;
  localparam int opt_proto_words = 15;  // Every option word a segment could ask for

  // Field types
  typedef logic [31:0] opt_word_t;
  typedef logic [3:0]  offset_t;
  typedef logic [2:0]  sack_cnt_t;
  typedef logic [15:0] port_t;
  typedef logic [31:0] seq_t;  // Sequence numbers, SACK edges, timestamps
  typedef logic [8:0]  flags_t;
  typedef logic [15:0] win_t;  // Window, urgent pointer, MSS

  // Byte arrays, byte 0 goes out first
  typedef logic [0:opt_block_bytes-1][7:0] opt_block_t;
  typedef logic [0:max_hdr_bytes-1][7:0]   hdr_bytes_t;

endpackage : tcp_proto_pkg
